// ==== vlog.f ====
+incdir+verilog
verilog/proc_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/proc.sv
verif/proc_tb.sv

// ==== Bender.yml ====
package:
  name: proc

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/proc_pkg.sv
      - verilog/fetch.sv
      - verilog/decode.sv
      - verilog/execute.sv
      - verilog/memory.sv
      - verilog/proc.sv
  - target: test
    files:
      - verif/proc_tb.sv

// ==== verif/proc_tb.sv ====
/*
 * Testbench for the five-stage pipelined processor
 * Random programs run on the DUT and on an instruction-level model
 */
`timescale 1ns/100ps
`include "proc_macros.svh"

module proc_tb;

   import proc_pkg::*;

   localparam int PROG_DEPTH  = 64;
   localparam int BODY_LEN    = 40;
   localparam int CYCLE_LIMIT = 2400;

   logic                    clk;
   logic                    rst_n_i;
   logic [`PROC_DATA_W-1:0] imem_addr_o;
   logic [`PROC_DATA_W-1:0] imem_data_i;
   logic                    wb_en_o;
   logic [`PROC_REG_AW-1:0] wb_reg_o;
   logic [`PROC_DATA_W-1:0] wb_data_o;
   logic                    halt_o;
   logic                    err_o;

   logic [`PROC_DATA_W-1:0] prog [PROG_DEPTH];
   logic [`PROC_REG_AW-1:0] exp_reg_q [$];
   logic [`PROC_DATA_W-1:0] exp_data_q [$];
   integer                  seed = 32'h839e0c94;
   int                      prog_len;
   int                      cycles = 0;
   int                      errors = 0;
   int                      tests_passed = 0;
   int                      tests_failed = 0;

   proc u_dut (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .imem_addr_o (imem_addr_o),
      .imem_data_i (imem_data_i),
      .wb_en_o     (wb_en_o),
      .wb_reg_o    (wb_reg_o),
      .wb_data_o   (wb_data_o),
      .halt_o      (halt_o),
      .err_o       (err_o)
   );

   // Instruction ROM answers in the same cycle
   assign imem_data_i = prog[imem_addr_o[5:0]];

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("Run stopped after %0d cycles without reaching the end", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   function automatic int pick(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [`PROC_DATA_W-1:0] encode(input int op, input int rd,
                                                       input int rs, input int low);
      return {op[3:0], rd[2:0], rs[2:0], low[5:0]};
   endfunction

   task automatic emit(input logic [`PROC_DATA_W-1:0] word);
      prog[prog_len] = word;
      prog_len++;
   endtask

   task automatic check_reg(input logic [`PROC_REG_AW-1:0] exp,
                            input logic [`PROC_REG_AW-1:0] act);
      if (act !== exp) begin
         $display("ERROR wb_reg_o expected 0x%h got 0x%h", exp, act);
         errors++;
      end
   endtask

   task automatic check_data(input logic [`PROC_DATA_W-1:0] exp,
                             input logic [`PROC_DATA_W-1:0] act);
      if (act !== exp) begin
         $display("ERROR wb_data_o expected 0x%h got 0x%h", exp, act);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR %s expected 0x%h got 0x%h", name, exp, act);
         errors++;
      end
   endtask

   // Instruction-level model that returns 1 when the program traps
   function automatic bit iss_run();
      logic [`PROC_DATA_W-1:0] regs [`PROC_REG_NUM];
      logic [`PROC_DATA_W-1:0] mem [`PROC_DMEM_DEPTH];
      logic [`PROC_DATA_W-1:0] inst;
      logic [`PROC_DATA_W-1:0] imm;
      logic [`PROC_DATA_W-1:0] addr;
      logic [`PROC_DATA_W-1:0] res;
      logic [3:0]              op;
      logic [2:0]              rd;
      logic [2:0]              rs;
      logic [2:0]              rt;
      int                      pc;
      bit                      wr;
      foreach (regs[i]) regs[i] = '0;
      foreach (mem[i]) mem[i] = '0;
      pc = 0;
      while (pc < PROG_DEPTH) begin
         inst = prog[pc];
         op   = inst[15:12];
         rd   = inst[11:9];
         rs   = inst[8:6];
         rt   = inst[5:3];
         imm  = {{10{inst[5]}}, inst[5:0]};
         addr = regs[rs] + imm;
         wr   = 1'b1;
         res  = '0;
         pc++;
         case (op)
            OP_NOP:  wr = 1'b0;
            OP_ADD:  res = regs[rs] + regs[rt];
            OP_SUB:  res = regs[rs] - regs[rt];
            OP_AND:  res = regs[rs] & regs[rt];
            OP_XOR:  res = regs[rs] ^ regs[rt];
            OP_ADDI: res = addr;
            OP_LD:   res = mem[addr[7:0]];
            OP_ST: begin
               mem[addr[7:0]] = regs[rd];
               wr = 1'b0;
            end
            OP_BEQZ: begin
               if (regs[rs] == '0) begin
                  pc = pc + $signed(imm);
               end
               wr = 1'b0;
            end
            OP_HALT: return 1'b0;
            default: return 1'b1;
         endcase
         if (wr) begin
            regs[rd] = res;
            exp_reg_q.push_back(rd);
            exp_data_q.push_back(res);
         end
      end
      return 1'b0;
   endfunction

   task automatic build_program(input int kind);
      int rd;
      int op;
      int base;
      int imm;
      int prev;
      foreach (prog[i]) prog[i] = '0;
      prog_len = 0;
      // Load from memory that nothing has written yet
      if (kind == 3) begin
         emit(encode(OP_LD, 7, 0, pick(64)));
      end
      for (int r = 0; r < `PROC_REG_NUM; r++) begin
         emit(encode(OP_ADDI, r, pick(8), (kind == 4) ? pick(2) : pick(64)));
      end
      prev = 0;
      while (prog_len < BODY_LEN) begin
         rd   = pick(8);
         base = pick(8);
         case (kind)
            0: emit(encode(OP_ADD + pick(4), rd, base, pick(8) * 8));
            1: emit(encode(OP_ADDI, rd, base, 32 + pick(32)));
            2: begin
               op = OP_ADD + pick(5);
               emit(encode(op, rd, prev, (op == OP_ADDI) ? pick(64) : prev * 8));
               prev = rd;
            end
            3: begin
               imm = pick(64);
               emit(encode(OP_ST, rd, base, imm));
               emit(encode(OP_LD, pick(8), base, pick(2) ? imm : pick(64)));
            end
            4: begin
               // Forward branches stay inside the program
               if (pick(3) == 0 && prog_len < BODY_LEN - 4) begin
                  emit(encode(OP_BEQZ, 0, base, 1 + pick(3)));
               end else if (pick(2) == 0) begin
                  emit(encode(OP_XOR, rd, base, base * 8));
               end else begin
                  emit(encode(OP_ADDI, rd, base, pick(2)));
               end
            end
            default: begin
               if (prog_len == 20) begin
                  emit(encode(10 + pick(6), rd, base, pick(64)));
               end else begin
                  emit(encode(OP_ADD + pick(5), rd, base, pick(64)));
               end
            end
         endcase
      end
      emit(encode(OP_HALT, 0, 0, 0));
   endtask

   // Every writeback is popped against the model
   always @(negedge clk) begin
      if (rst_n_i && wb_en_o) begin
         if (exp_reg_q.size() == 0) begin
            $display("Register r%0d was written when no write was expected", wb_reg_o);
            errors++;
         end else begin
            check_reg(exp_reg_q.pop_front(), wb_reg_o);
            check_data(exp_data_q.pop_front(), wb_data_o);
         end
      end
   end

   task automatic run_test(input int kind, input string name);
      bit err_exp;
      @(posedge clk);
      rst_n_i <= 1'b0;
      @(posedge clk);
      exp_reg_q.delete();
      exp_data_q.delete();
      build_program(kind);
      err_exp = iss_run();
      errors  = 0;
      repeat (15) @(posedge clk);
      rst_n_i <= 1'b1;
      @(posedge clk);
      while (!(halt_o || err_o)) begin
         @(posedge clk);
      end
      // HALT reaches MEM/WB only after every older write
      if (halt_o && exp_reg_q.size() != 0) begin
         $display("halt_o rose with %0d register writes still expected", exp_reg_q.size());
         errors++;
      end
      // Up to three older instructions still in flight after a trap
      repeat (4) @(posedge clk);
      check_flag("halt_o", !err_exp, halt_o);
      check_flag("err_o", err_exp, err_o);
      if (exp_reg_q.size() != 0) begin
         $display("%0d expected register writes never appeared", exp_reg_q.size());
         errors += exp_reg_q.size();
      end
      if (errors == 0) begin
         tests_passed++;
         $display("Test %0d %s: passed", kind + 1, name);
      end else begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", kind + 1, name, errors);
      end
   endtask

   initial begin
      clk     = 1'b0;
      rst_n_i = 1'b0;
      foreach (prog[i]) prog[i] = '0;
      run_test(0, "register ops");
      run_test(1, "negative immediates");
      run_test(2, "dependent chain");
      run_test(3, "store and load");
      run_test(4, "branches");
      run_test(5, "illegal opcode");
      $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog/proc.sv ====
/*
 * Five-stage pipelined processor top level
 * Wires fetch, decode, execute and memory to the ports
 */
`timescale 1ns/100ps
`include "proc_macros.svh"

module proc (
   input  logic                    clk,
   input  logic                    rst_n_i,
   output logic [`PROC_DATA_W-1:0] imem_addr_o,
   input  logic [`PROC_DATA_W-1:0] imem_data_i,
   output logic                    wb_en_o,
   output logic [`PROC_REG_AW-1:0] wb_reg_o,
   output logic [`PROC_DATA_W-1:0] wb_data_o,
   output logic                    halt_o,
   output logic                    err_o
);

   import proc_pkg::*;

   // Fetch and decode
   logic                    stall;
   logic                    redirect;
   logic [`PROC_DATA_W-1:0] target;
   logic [`PROC_DATA_W-1:0] inst;
   logic [`PROC_DATA_W-1:0] pc_next;

   // ID/EX
   opcode_e                 ex_op;
   logic [`PROC_REG_AW-1:0] ex_rd;
   logic [`PROC_DATA_W-1:0] ex_a;
   logic [`PROC_DATA_W-1:0] ex_b;
   logic [`PROC_DATA_W-1:0] ex_imm;

   // EX/MEM
   opcode_e                 mem_op;
   logic [`PROC_REG_AW-1:0] mem_rd;
   logic [`PROC_DATA_W-1:0] mem_alu;
   logic [`PROC_DATA_W-1:0] mem_store;

   fetch u_fetch (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .stall_i     (stall),
      .redirect_i  (redirect),
      .target_i    (target),
      .imem_addr_o (imem_addr_o),
      .imem_data_i (imem_data_i),
      .inst_o      (inst),
      .pc_next_o   (pc_next)
   );

   decode u_decode (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .inst_i     (inst),
      .pc_next_i  (pc_next),
      .wb_en_i    (wb_en_o),
      .wb_reg_i   (wb_reg_o),
      .wb_data_i  (wb_data_o),
      .mem_op_i   (mem_op),
      .mem_rd_i   (mem_rd),
      .stall_o    (stall),
      .redirect_o (redirect),
      .target_o   (target),
      .err_o      (err_o),
      .ex_op_o    (ex_op),
      .ex_rd_o    (ex_rd),
      .ex_a_o     (ex_a),
      .ex_b_o     (ex_b),
      .ex_imm_o   (ex_imm)
   );

   execute u_execute (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .ex_op_i     (ex_op),
      .ex_rd_i     (ex_rd),
      .ex_a_i      (ex_a),
      .ex_b_i      (ex_b),
      .ex_imm_i    (ex_imm),
      .mem_op_o    (mem_op),
      .mem_rd_o    (mem_rd),
      .mem_alu_o   (mem_alu),
      .mem_store_o (mem_store)
   );

   memory u_memory (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .mem_op_i    (mem_op),
      .mem_rd_i    (mem_rd),
      .mem_alu_i   (mem_alu),
      .mem_store_i (mem_store),
      .wb_en_o     (wb_en_o),
      .wb_reg_o    (wb_reg_o),
      .wb_data_o   (wb_data_o),
      .halt_o      (halt_o)
   );

endmodule

// ==== verilog/memory.sv ====
/*
 * Memory stage
 * Data RAM, writeback select, MEM/WB register and the halt flag
 */
`timescale 1ns/100ps
`include "proc_macros.svh"

module memory (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  proc_pkg::opcode_e       mem_op_i,
   input  logic [`PROC_REG_AW-1:0] mem_rd_i,
   input  logic [`PROC_DATA_W-1:0] mem_alu_i,
   input  logic [`PROC_DATA_W-1:0] mem_store_i,
   output logic                    wb_en_o,
   output logic [`PROC_REG_AW-1:0] wb_reg_o,
   output logic [`PROC_DATA_W-1:0] wb_data_o,
   output logic                    halt_o
);

   import proc_pkg::*;

   localparam int DMEM_AW = $clog2(`PROC_DMEM_DEPTH);

   logic [`PROC_DATA_W-1:0] dmem_q [`PROC_DMEM_DEPTH];
   logic [DMEM_AW-1:0]      addr;
   logic [`PROC_DATA_W-1:0] wb_val;

   assign addr   = mem_alu_i[DMEM_AW-1:0];
   // Load data read combinationally
   assign wb_val = (mem_op_i == OP_LD) ? dmem_q[addr] : mem_alu_i;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `PROC_DMEM_DEPTH; i++) begin
            dmem_q[i] <= '0;
         end
      end else if (mem_op_i == OP_ST) begin
         dmem_q[addr] <= mem_store_i;
      end
   end

   // MEM/WB and sticky halt
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wb_en_o   <= 1'b0;
         wb_reg_o  <= '0;
         wb_data_o <= '0;
         halt_o    <= 1'b0;
      end else begin
         wb_en_o   <= op_writes_reg(mem_op_i);
         wb_reg_o  <= mem_rd_i;
         wb_data_o <= wb_val;
         if (mem_op_i == OP_HALT) begin
            halt_o <= 1'b1;
         end
      end
   end

endmodule

// ==== verilog/execute.sv ====
/*
 * Execute stage
 * ALU and address adder chosen by opcode, feeding the EX/MEM register
 */
`timescale 1ns/100ps
`include "proc_macros.svh"

module execute (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  proc_pkg::opcode_e       ex_op_i,
   input  logic [`PROC_REG_AW-1:0] ex_rd_i,
   input  logic [`PROC_DATA_W-1:0] ex_a_i,
   input  logic [`PROC_DATA_W-1:0] ex_b_i,
   input  logic [`PROC_DATA_W-1:0] ex_imm_i,
   output proc_pkg::opcode_e       mem_op_o,
   output logic [`PROC_REG_AW-1:0] mem_rd_o,
   output logic [`PROC_DATA_W-1:0] mem_alu_o,
   output logic [`PROC_DATA_W-1:0] mem_store_o
);

   import proc_pkg::*;

   logic [`PROC_DATA_W-1:0] addr_sum;
   logic [`PROC_DATA_W-1:0] result;

   // Base plus offset for ADDI and memory ops
   assign addr_sum = ex_a_i + ex_imm_i;

   always_comb begin
      case (ex_op_i)
         OP_ADD:               result = ex_a_i + ex_b_i;
         OP_SUB:               result = ex_a_i - ex_b_i;
         OP_AND:               result = ex_a_i & ex_b_i;
         OP_XOR:               result = ex_a_i ^ ex_b_i;
         OP_ADDI, OP_LD, OP_ST: result = addr_sum;
         default:              result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         mem_op_o    <= OP_NOP;
         mem_rd_o    <= '0;
         mem_alu_o   <= '0;
         mem_store_o <= '0;
      end else begin
         mem_op_o    <= ex_op_i;
         mem_rd_o    <= ex_rd_i;
         mem_alu_o   <= result;
         mem_store_o <= ex_b_i;
      end
   end

endmodule

// ==== verilog/decode.sv ====
/*
 * Decode stage
 * Register file with write bypass, hazard stall, BEQZ resolution,
 * HALT and illegal opcode trap, and the ID/EX register
 */
`timescale 1ns/100ps
`include "proc_macros.svh"

module decode (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic [`PROC_DATA_W-1:0] inst_i,
   input  logic [`PROC_DATA_W-1:0] pc_next_i,
   input  logic                    wb_en_i,
   input  logic [`PROC_REG_AW-1:0] wb_reg_i,
   input  logic [`PROC_DATA_W-1:0] wb_data_i,
   input  proc_pkg::opcode_e       mem_op_i,
   input  logic [`PROC_REG_AW-1:0] mem_rd_i,
   output logic                    stall_o,
   output logic                    redirect_o,
   output logic [`PROC_DATA_W-1:0] target_o,
   output logic                    err_o,
   output proc_pkg::opcode_e       ex_op_o,
   output logic [`PROC_REG_AW-1:0] ex_rd_o,
   output logic [`PROC_DATA_W-1:0] ex_a_o,
   output logic [`PROC_DATA_W-1:0] ex_b_o,
   output logic [`PROC_DATA_W-1:0] ex_imm_o
);

   import proc_pkg::*;

   logic [`PROC_DATA_W-1:0] rf_q [`PROC_REG_NUM];

   logic [3:0]              op_raw;
   opcode_e                 op;
   logic [`PROC_REG_AW-1:0] rd;
   logic [`PROC_REG_AW-1:0] rs;
   logic [`PROC_REG_AW-1:0] rt;
   logic [`PROC_DATA_W-1:0] imm_ext;
   logic [`PROC_DATA_W-1:0] rs_val;
   logic [`PROC_DATA_W-1:0] rt_val;
   logic [`PROC_DATA_W-1:0] rd_val;
   logic                    uses_rs;
   logic                    uses_rt;
   logic                    uses_rd;
   logic                    ex_wr;
   logic                    mem_wr;
   logic                    rs_busy;
   logic                    rt_busy;
   logic                    rd_busy;
   logic                    hazard;
   logic                    illegal;
   logic                    stop_q;

   // Field split
   assign op_raw  = inst_i[OPC_HI:OPC_LO];
   assign op      = opcode_e'(op_raw);
   assign rd      = inst_i[RD_HI:RD_LO];
   assign rs      = inst_i[RS_HI:RS_LO];
   assign rt      = inst_i[RT_HI:RT_LO];
   assign imm_ext = {{(`PROC_DATA_W-IMM_HI-1){inst_i[IMM_HI]}}, inst_i[IMM_HI:IMM_LO]};
   assign illegal = (op_raw > OP_HALT) && !stop_q;

   // Reads see a write landing in the same cycle
   assign rs_val = (wb_en_i && wb_reg_i == rs) ? wb_data_i : rf_q[rs];
   assign rt_val = (wb_en_i && wb_reg_i == rt) ? wb_data_i : rf_q[rt];
   assign rd_val = (wb_en_i && wb_reg_i == rd) ? wb_data_i : rf_q[rd];

   // Source registers read by each opcode
   always_comb begin
      uses_rs = 1'b0;
      uses_rt = 1'b0;
      uses_rd = 1'b0;
      case (op)
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
         end
         OP_ADDI, OP_LD, OP_BEQZ: uses_rs = 1'b1;
         OP_ST: begin
            uses_rs = 1'b1;
            uses_rd = 1'b1;
         end
         default: ;
      endcase
   end

   // Pending writers in ID/EX and EX/MEM
   assign ex_wr   = op_writes_reg(ex_op_o);
   assign mem_wr  = op_writes_reg(mem_op_i);
   assign rs_busy = (ex_wr && ex_rd_o == rs) || (mem_wr && mem_rd_i == rs);
   assign rt_busy = (ex_wr && ex_rd_o == rt) || (mem_wr && mem_rd_i == rt);
   assign rd_busy = (ex_wr && ex_rd_o == rd) || (mem_wr && mem_rd_i == rd);
   assign hazard  = (uses_rs && rs_busy) || (uses_rt && rt_busy) || (uses_rd && rd_busy);

   assign stall_o    = hazard || stop_q;
   assign redirect_o = (op == OP_BEQZ) && !stall_o && (rs_val == '0);
   assign target_o   = pc_next_i + imm_ext;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `PROC_REG_NUM; i++) begin
            rf_q[i] <= '0;
         end
      end else if (wb_en_i) begin
         rf_q[wb_reg_i] <= wb_data_i;
      end
   end

   // Sticky stop on HALT or a bad opcode
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         stop_q <= 1'b0;
         err_o  <= 1'b0;
      end else begin
         if ((op == OP_HALT && !stop_q) || illegal) begin
            stop_q <= 1'b1;
         end
         if (illegal) begin
            err_o <= 1'b1;
         end
      end
   end

   // ID/EX takes a bubble on stall or trap
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ex_op_o  <= OP_NOP;
         ex_rd_o  <= '0;
         ex_a_o   <= '0;
         ex_b_o   <= '0;
         ex_imm_o <= '0;
      end else if (stall_o || illegal) begin
         ex_op_o <= OP_NOP;
         ex_rd_o <= '0;
      end else begin
         ex_op_o  <= op;
         ex_rd_o  <= rd;
         ex_a_o   <= rs_val;
         ex_b_o   <= (op == OP_ST) ? rd_val : rt_val;
         ex_imm_o <= imm_ext;
      end
   end

endmodule

// ==== verilog/fetch.sv ====
/*
 * Fetch stage
 * Program counter and the IF/ID register, with stall and redirect
 */
`timescale 1ns/100ps
`include "proc_macros.svh"

module fetch (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    stall_i,
   input  logic                    redirect_i,
   input  logic [`PROC_DATA_W-1:0] target_i,
   output logic [`PROC_DATA_W-1:0] imem_addr_o,
   input  logic [`PROC_DATA_W-1:0] imem_data_i,
   output logic [`PROC_DATA_W-1:0] inst_o,
   output logic [`PROC_DATA_W-1:0] pc_next_o
);

   logic [`PROC_DATA_W-1:0] pc_q;
   logic [`PROC_DATA_W-1:0] pc_inc;

   assign pc_inc      = pc_q + 1'b1;
   assign imem_addr_o = pc_q;

   // Redirect wins over stall and squashes the fetched word
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q      <= '0;
         inst_o    <= '0;
         pc_next_o <= '0;
      end else if (redirect_i) begin
         pc_q      <= target_i;
         inst_o    <= '0;
         pc_next_o <= '0;
      end else if (!stall_i) begin
         pc_q      <= pc_inc;
         inst_o    <= imem_data_i;
         pc_next_o <= pc_inc;
      end
   end

endmodule

// ==== verilog/proc_pkg.sv ====
/*
 * Processor package with the opcode encoding and instruction field positions.
 * ST stores register rd. BEQZ tests rs and, when taken, jumps to the
 * branch PC plus one plus imm6. PCs count words.
 */
package proc_pkg;

   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_ADD  = 4'd1,
      OP_SUB  = 4'd2,
      OP_AND  = 4'd3,
      OP_XOR  = 4'd4,
      OP_ADDI = 4'd5,
      OP_LD   = 4'd6,
      OP_ST   = 4'd7,
      OP_BEQZ = 4'd8,
      OP_HALT = 4'd9
   } opcode_e;

   // Field bit positions
   localparam int OPC_HI = 15;
   localparam int OPC_LO = 12;
   localparam int RD_HI  = 11;
   localparam int RD_LO  = 9;
   localparam int RS_HI  = 8;
   localparam int RS_LO  = 6;
   localparam int RT_HI  = 5;
   localparam int RT_LO  = 3;
   localparam int IMM_HI = 5;
   localparam int IMM_LO = 0;

   // Opcodes that write register rd
   function automatic logic op_writes_reg(input opcode_e op);
      return (op == OP_ADD) || (op == OP_SUB) || (op == OP_AND) ||
             (op == OP_XOR) || (op == OP_ADDI) || (op == OP_LD);
   endfunction

endpackage

// ==== verilog/proc_macros.svh ====
/*
 * Processor sizing macros
 * Data path width, register file geometry and data RAM depth
 */
`ifndef PROC_MACROS_SVH
`define PROC_MACROS_SVH

// Data and instruction word width
`define PROC_DATA_W 16

// Register file
`define PROC_REG_NUM 8
`define PROC_REG_AW 3

// Data RAM words indexed by the low address bits
`define PROC_DMEM_DEPTH 256

`endif
